//--- Makefile
VERILATOR := verilator
TOP       := rv_core_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Result: PASSED

SRCS := $(wildcard logic/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)

.PHONY: all run clean

all: run

# Rebuild only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/rv_core.sv
`timescale 1ns/10ps

module rv_core
  import rv_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,

  // Instruction memory, read only
  output word_t  imem_raddr,
  input  instr_t imem_rdata,

  // Data memory read
  output logic   dmem_ren,
  output word_t  dmem_raddr,
  input  word_t  dmem_rdata,

  // Data memory write
  output logic   dmem_we,
  output word_t  dmem_waddr,
  output word_t  dmem_wdata,

  output logic   ebreak
);

  // Fetch
  word_t      pc;
  word_t      pc_plus4;
  logic       pc_sel;
  word_t      jb_target;

  // Decode
  logic       reg_write;
  logic       mem_read;
  logic       mem_write;
  alu_a_src_e alu_a_src;
  logic       alu_b_imm;
  alu_op_e    alu_op;
  res_src_e   res_src;
  logic       is_branch;
  logic       is_jump;
  logic       is_jalr;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  logic [2:0] funct3;
  word_t      imm;

  // Register file and write-back
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      alu_result;
  logic       rd_en;
  word_t      rd_data;

  // --------------------
  // Stages
  rv_fetch u_fetch (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc_sel    (pc_sel),
    .jb_target (jb_target),
    .pc        (pc),
    .pc_plus4  (pc_plus4)
  );

  rv_decode u_decode (
    .instr     (imem_rdata),
    .reg_write (reg_write),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .alu_a_src (alu_a_src),
    .alu_b_imm (alu_b_imm),
    .alu_op    (alu_op),
    .res_src   (res_src),
    .is_branch (is_branch),
    .is_jump   (is_jump),
    .is_jalr   (is_jalr),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .funct3    (funct3),
    .imm       (imm)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd_en    (rd_en),
    .rd       (rd),
    .rd_data  (rd_data)
  );

  rv_execute u_execute (
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm        (imm),
    .alu_a_src  (alu_a_src),
    .alu_b_imm  (alu_b_imm),
    .alu_op     (alu_op),
    .funct3     (funct3),
    .is_branch  (is_branch),
    .is_jump    (is_jump),
    .is_jalr    (is_jalr),
    .alu_result (alu_result),
    .pc_sel     (pc_sel),
    .jb_target  (jb_target)
  );

  rv_result u_result (
    .res_src    (res_src),
    .reg_write  (reg_write),
    .rd         (rd),
    .alu_result (alu_result),
    .load_data  (dmem_rdata),
    .pc_plus4   (pc_plus4),
    .rd_en      (rd_en),
    .rd_data    (rd_data)
  );

  // --------------------
  // Memory ports
  assign imem_raddr = pc;

  // Same address for loads and stores
  assign dmem_ren   = mem_read;
  assign dmem_raddr = alu_result;
  assign dmem_we    = mem_write;
  assign dmem_waddr = alu_result;
  assign dmem_wdata = rs2_data;

  // Halt marker for the environment
  assign ebreak = rst_n && (imem_rdata == I_EBREAK);

endmodule

//--- logic/rv_decode.sv
`timescale 1ns/10ps

module rv_decode
  import rv_pkg::*;
(
  input  instr_t     instr,
  output logic       reg_write,
  output logic       mem_read,
  output logic       mem_write,
  output alu_a_src_e alu_a_src,
  output logic       alu_b_imm,
  output alu_op_e    alu_op,
  output res_src_e   res_src,
  output logic       is_branch,
  output logic       is_jump,
  output logic       is_jalr,
  output reg_addr_t  rs1,
  output reg_addr_t  rs2,
  output reg_addr_t  rd,
  output logic [2:0] funct3,
  output word_t      imm
);

  logic [6:0] opcode;
  logic       funct7_b5;
  imm_type_e  imm_type;
  alu_op_e    arith_op;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  // Fixed instruction fields
  assign opcode    = instr[6:0];
  assign rd        = instr[11:7];
  assign funct3    = instr[14:12];
  assign rs1       = instr[19:15];
  assign rs2       = instr[24:20];
  assign funct7_b5 = instr[30];

  // --------------------
  // ALU operation for OP and OP-IMM
  always_comb begin
    case (funct3)
      // SUB exists only in register form
      3'b000:  arith_op = (opcode == OP_REG && funct7_b5) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      // Both shift forms carry the arithmetic flag in bit 30
      3'b101:  arith_op = funct7_b5 ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  // --------------------
  // Main control decode
  always_comb begin
    // Defaults describe a harmless no-op
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    alu_a_src = ALU_A_RS1;
    alu_b_imm = 1'b0;
    alu_op    = ALU_ADD;
    res_src   = RES_ALU;
    imm_type  = IMM_I;
    is_branch = 1'b0;
    is_jump   = 1'b0;
    is_jalr   = 1'b0;

    case (opcode)
      OP_LUI: begin
        reg_write = 1'b1;
        alu_a_src = ALU_A_ZERO;
        alu_b_imm = 1'b1;
        alu_op    = ALU_PASS_B;
        imm_type  = IMM_U;
      end
      OP_AUIPC: begin
        reg_write = 1'b1;
        alu_a_src = ALU_A_PC;
        alu_b_imm = 1'b1;
        imm_type  = IMM_U;
      end
      OP_JAL: begin
        // Link value written, target from the PC adder
        reg_write = 1'b1;
        res_src   = RES_PC_PLUS4;
        imm_type  = IMM_J;
        is_jump   = 1'b1;
      end
      OP_JALR: begin
        // Target comes from rs1 + imm through the ALU
        reg_write = 1'b1;
        alu_b_imm = 1'b1;
        res_src   = RES_PC_PLUS4;
        is_jump   = 1'b1;
        is_jalr   = 1'b1;
      end
      OP_BRANCH: begin
        imm_type  = IMM_B;
        is_branch = 1'b1;
      end
      OP_LOAD: begin
        reg_write = 1'b1;
        mem_read  = 1'b1;
        alu_b_imm = 1'b1;
        res_src   = RES_MEM;
      end
      OP_STORE: begin
        mem_write = 1'b1;
        alu_b_imm = 1'b1;
        imm_type  = IMM_S;
      end
      OP_IMM: begin
        reg_write = 1'b1;
        alu_b_imm = 1'b1;
        alu_op    = arith_op;
      end
      OP_REG: begin
        reg_write = 1'b1;
        alu_op    = arith_op;
      end
      // SYSTEM and unknown opcodes keep the defaults
      default: begin
      end
    endcase
  end

  // --------------------
  // Immediate forms, sign taken from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (imm_type)
      IMM_S:   imm = imm_s;
      IMM_B:   imm = imm_b;
      IMM_U:   imm = imm_u;
      IMM_J:   imm = imm_j;
      default: imm = imm_i;
    endcase
  end

  // One data memory access per instruction at most
  always_comb begin
    a_one_mem_access: assert final (!(mem_read && mem_write));
  end

endmodule

//--- logic/rv_execute.sv
`timescale 1ns/10ps

module rv_execute
  import rv_pkg::*;
(
  input  word_t      pc,
  input  word_t      rs1_data,
  input  word_t      rs2_data,
  input  word_t      imm,
  input  alu_a_src_e alu_a_src,
  input  logic       alu_b_imm,
  input  alu_op_e    alu_op,
  input  logic [2:0] funct3,
  input  logic       is_branch,
  input  logic       is_jump,
  input  logic       is_jalr,
  output word_t      alu_result,
  output logic       pc_sel,
  output word_t      jb_target
);

  word_t alu_a;
  word_t alu_b;
  logic  alu_lt;
  logic  alu_ltu;
  logic  br_eq;
  logic  br_lt;
  logic  br_ltu;
  logic  br_taken;
  word_t pc_rel_target;

  // --------------------
  // Operand muxes
  always_comb begin
    case (alu_a_src)
      ALU_A_PC:   alu_a = pc;
      ALU_A_ZERO: alu_a = '0;
      default:    alu_a = rs1_data;
    endcase
  end

  assign alu_b = alu_b_imm ? imm : rs2_data;

  // Set-less-than compares
  assign alu_lt  = $signed(alu_a) < $signed(alu_b);
  assign alu_ltu = alu_a < alu_b;

  // --------------------
  // ALU
  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_result = alu_a + alu_b;
      ALU_SUB:    alu_result = alu_a - alu_b;
      ALU_SLL:    alu_result = alu_a << alu_b[4:0];
      ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, alu_lt};
      ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, alu_ltu};
      ALU_XOR:    alu_result = alu_a ^ alu_b;
      ALU_SRL:    alu_result = alu_a >> alu_b[4:0];
      // Sign fill on arithmetic shift
      ALU_SRA:    alu_result = word_t'($signed(alu_a) >>> alu_b[4:0]);
      ALU_OR:     alu_result = alu_a | alu_b;
      ALU_AND:    alu_result = alu_a & alu_b;
      ALU_PASS_B: alu_result = alu_b;
      default:    alu_result = '0;
    endcase
  end

  // --------------------
  // Branch compare on the raw register values
  assign br_eq  = rs1_data == rs2_data;
  assign br_lt  = $signed(rs1_data) < $signed(rs2_data);
  assign br_ltu = rs1_data < rs2_data;

  always_comb begin
    case (funct3)
      F3_BEQ:  br_taken = br_eq;
      F3_BNE:  br_taken = !br_eq;
      F3_BLT:  br_taken = br_lt;
      F3_BGE:  br_taken = !br_lt;
      F3_BLTU: br_taken = br_ltu;
      F3_BGEU: br_taken = !br_ltu;
      default: br_taken = 1'b0;
    endcase
  end

  // Dedicated adder for JAL and branches
  assign pc_rel_target = pc + imm;

  // JALR drops the low bit of the sum
  assign jb_target = is_jalr ? {alu_result[XLEN-1:1], 1'b0} : pc_rel_target;

  assign pc_sel = is_jump || (is_branch && br_taken);

  // Redirects land on whole words only
  always_comb begin
    a_target_aligned: assert final (!pc_sel || jb_target[1:0] == 2'b00);
  end

endmodule

//--- logic/rv_fetch.sv
`timescale 1ns/10ps

module rv_fetch
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  pc_sel,
  input  word_t jb_target,
  output word_t pc,
  output word_t pc_plus4
);

  word_t pc_next;

  // Sequential address
  assign pc_plus4 = pc + word_t'(4);

  // Redirect on taken branch or any jump
  assign pc_next = pc_sel ? jb_target : pc_plus4;

  // --------------------
  // PC register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Boot from address 0
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // Fetch address must stay on a word boundary
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    pc[1:0] == 2'b00
  );

endmodule

//--- logic/rv_pkg.sv
package rv_pkg;

  // Datapath widths
  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [REG_AW-1:0] reg_addr_t;
  typedef logic [31:0]       instr_t;

  // --------------------
  // Major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // Fixed encodings
  localparam instr_t I_EBREAK = 32'h0010_0073;
  localparam instr_t I_NOP    = 32'h0000_0013;

  // Branch conditions in funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // --------------------
  // Control encodings
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {ALU_A_RS1, ALU_A_ZERO, ALU_A_PC} alu_a_src_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_type_e;

  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC_PLUS4} res_src_e;

endpackage

//--- logic/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  logic      rd_en,
  input  reg_addr_t rd,
  input  word_t     rd_data
);

  localparam int NREGS = 2 ** REG_AW;

  word_t regs [NREGS];

  // --------------------
  // Write port
  // x0 filtering happens upstream in the result stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_en) begin
      regs[rd] <= rd_data;
    end
  end

  // --------------------
  // Read ports
  // No bypass, a write shows up after the edge
  always_comb begin
    rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    rs2_data = (rs2 == '0) ? '0 : regs[rs2];
  end

endmodule

//--- logic/rv_result.sv
`timescale 1ns/10ps

module rv_result
  import rv_pkg::*;
(
  input  res_src_e  res_src,
  input  logic      reg_write,
  input  reg_addr_t rd,
  input  word_t     alu_result,
  input  word_t     load_data,
  input  word_t     pc_plus4,
  output logic      rd_en,
  output word_t     rd_data
);

  // Write-back source
  always_comb begin
    case (res_src)
      RES_MEM:      rd_data = load_data;
      RES_PC_PLUS4: rd_data = pc_plus4;
      default:      rd_data = alu_result;
    endcase
  end

  // x0 is never written
  assign rd_en = reg_write && (rd != '0);

endmodule

//--- verif/rv_tb_programs.svh
`ifndef RV_TB_PROGRAMS_SVH
`define RV_TB_PROGRAMS_SVH

// --------------------
// Instruction encoders
function automatic instr_t r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                  input logic [2:0] f3, input int rd, input logic [6:0] op);
  return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op};
endfunction

function automatic instr_t i_type(input int imm, input int rs1, input logic [2:0] f3,
                                  input int rd, input logic [6:0] op);
  return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
endfunction

function automatic instr_t s_type(input int imm, input int rs2, input int rs1,
                                  input logic [2:0] f3);
  return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], OP_STORE};
endfunction

function automatic instr_t b_type(input int off, input int rs2, input int rs1,
                                  input logic [2:0] f3);
  return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OP_BRANCH};
endfunction

function automatic instr_t u_type(input int imm20, input int rd, input logic [6:0] op);
  return {imm20[19:0], rd[4:0], op};
endfunction

function automatic instr_t j_type(input int off, input int rd);
  return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
endfunction

// Append one word to the program image
task automatic emit(input instr_t instr);
  imem[prog_len[7:0]] = instr;
  prog_len++;
endtask

// --------------------
// Op tables, funct3 plus bit 30
localparam logic [2:0] ALU_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                       3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
localparam logic ALU_ALT [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
                                  1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
localparam logic [2:0] BR_F3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};

// Branch path markers
localparam int MARK_FALL  = 'h111;
localparam int MARK_TAKEN = 'h222;

// Address of the EBREAK word in the probe program
localparam word_t EBREAK_AT = 32'd20;

// --------------------
// Program builders
task automatic halt_program();
  emit(I_NOP);
  emit(I_EBREAK);
endtask

task automatic alu_program(input int imm12, input int shamt);
  int imm;
  emit(I_NOP);
  // Operands from data words 0 and 1
  emit(i_type(0, 0, 3'd2, 1, OP_LOAD));
  emit(i_type(4, 0, 3'd2, 2, OP_LOAD));
  // Register forms into words 16 and up
  for (int k = 0; k < 10; k++) begin
    emit(r_type(ALU_ALT[k] ? 7'h20 : 7'h00, 2, 1, ALU_F3[k], 3, OP_REG));
    emit(s_type(64 + 4 * k, 3, 0, 3'd2));
  end
  // Immediate forms into words 32 and up, no SUBI
  for (int k = 0; k < 10; k++) begin
    if (k != 1) begin
      if (ALU_F3[k] == 3'd1 || ALU_F3[k] == 3'd5) begin
        imm = (ALU_ALT[k] ? 'h400 : 0) + shamt;
      end else begin
        imm = imm12;
      end
      emit(i_type(imm, 1, ALU_F3[k], 4, OP_IMM));
      emit(s_type(128 + 4 * k, 4, 0, 3'd2));
    end
  end
  // Write to x0, then store x0 into word 48
  emit(i_type(7, 1, 3'd0, 0, OP_IMM));
  emit(s_type(192, 0, 0, 3'd2));
  emit(I_EBREAK);
endtask

task automatic branch_program(input logic [2:0] f3);
  emit(I_NOP);
  emit(i_type(0, 0, 3'd2, 1, OP_LOAD));
  emit(i_type(4, 0, 3'd2, 2, OP_LOAD));
  emit(b_type(12, 2, 1, f3));
  emit(i_type(MARK_FALL, 0, 3'd0, 3, OP_IMM));
  emit(j_type(8, 0));
  emit(i_type(MARK_TAKEN, 0, 3'd0, 3, OP_IMM));
  emit(s_type(64, 3, 0, 3'd2));
  emit(I_EBREAK);
endtask

task automatic jump_program(input int lui_imm, input int auipc_imm);
  emit(I_NOP);
  // JAL at 0x4 to 0x10
  emit(j_type(12, 1));
  emit(i_type(1, 0, 3'd0, 6, OP_IMM));
  emit(s_type(72, 6, 0, 3'd2));
  emit(s_type(64, 1, 0, 3'd2));
  // JALR at 0x18, 39 + 2 is odd and lands on 0x28
  emit(i_type(39, 0, 3'd0, 2, OP_IMM));
  emit(i_type(2, 2, 3'd0, 3, OP_JALR));
  emit(i_type(2, 0, 3'd0, 6, OP_IMM));
  emit(s_type(72, 6, 0, 3'd2));
  emit(I_EBREAK);
  emit(s_type(68, 3, 0, 3'd2));
  emit(u_type(lui_imm, 4, OP_LUI));
  emit(s_type(76, 4, 0, 3'd2));
  // AUIPC sits at 0x34
  emit(u_type(auipc_imm, 5, OP_AUIPC));
  emit(s_type(80, 5, 0, 3'd2));
  emit(s_type(72, 6, 0, 3'd2));
  emit(I_EBREAK);
endtask

task automatic load_store_program();
  emit(I_NOP);
  emit(i_type(32, 0, 3'd2, 1, OP_LOAD));
  emit(i_type(36, 0, 3'd2, 2, OP_LOAD));
  emit(r_type(7'h00, 2, 1, 3'd0, 3, OP_REG));
  emit(s_type(96, 3, 0, 3'd2));
  emit(i_type(40, 0, 3'd2, 4, OP_LOAD));
  emit(i_type(44, 0, 3'd2, 5, OP_LOAD));
  emit(r_type(7'h00, 5, 4, 3'd0, 6, OP_REG));
  emit(s_type(100, 6, 0, 3'd2));
  emit(r_type(7'h00, 6, 3, 3'd0, 7, OP_REG));
  emit(s_type(104, 7, 0, 3'd2));
  emit(I_EBREAK);
endtask

task automatic ebreak_program();
  emit(I_NOP);
  for (int k = 1; k < 5; k++) begin
    emit(i_type(k, 0, 3'd0, k, OP_IMM));
  end
  emit(I_EBREAK);
endtask

`endif

//--- verif/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb
  import rv_pkg::*;
();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 3;
  localparam int MEM_WORDS    = 256;
  localparam int PROG_CYCLES  = 64;
  localparam int PROBE_CYCLES = 10;
  // Reset, ALU, 12 branch programs, jumps, load/store, ebreak
  localparam int N_RUNS       = 17;
  localparam int WATCHDOG_NS  =
    N_RUNS * (PROG_CYCLES + RESET_CYCLES + 2) * CLK_PERIOD + 500;

  logic   clk;
  logic   rst_n;
  word_t  imem_raddr;
  instr_t imem_rdata;
  logic   dmem_ren;
  word_t  dmem_raddr;
  word_t  dmem_rdata;
  logic   dmem_we;
  word_t  dmem_waddr;
  word_t  dmem_wdata;
  logic   ebreak;

  instr_t imem [MEM_WORDS];
  word_t  dmem [MEM_WORDS];
  int     prog_len;
  int     seed = 32'h51b0_f44c;
  string  cur_test;
  int     test_errors;
  int     total_errors;
  int     tests_run;
  int     tests_failed;

  rv_core dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .ebreak     (ebreak)
  );

  `include "rv_tb_programs.svh"

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Combinational reads, word indexed
  assign imem_rdata = imem[imem_raddr[9:2]];
  // Load data only while the read enable is up
  assign dmem_rdata = dmem_ren ? dmem[dmem_raddr[9:2]] : 'x;

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog: run exceeded %0d ns without finishing", WATCHDOG_NS);
    $display("Result: FAILED");
    $finish;
  end

  // --------------------
  // Bookkeeping and compares
  task automatic note_error();
    test_errors++;
    total_errors++;
  endtask

  task automatic check_word(input string label, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, label, exp, act);
      note_error();
    end
  endtask

  task automatic check_flag(input string label, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %b, actual %b", cur_test, label, exp, act);
      note_error();
    end
  endtask

  task automatic open_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic close_test();
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("Test %s finished, %0d error(s)", cur_test, test_errors);
  endtask

  // --------------------
  // Reference rules
  function automatic word_t expect_alu(input logic [2:0] f3, input logic alt,
                                       input word_t a, input word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      // Logical shift, then refill the top bits for SRA
      3'd5:    return (a >> b[4:0]) |
                      ((alt && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_rule(input logic [2:0] f3, input word_t l, input word_t r);
    case (f3)
      F3_BEQ:  return l == r;
      F3_BNE:  return l != r;
      F3_BLT:  return $signed(l) < $signed(r);
      F3_BGE:  return !($signed(l) < $signed(r));
      F3_BLTU: return l < r;
      default: return !(l < r);
    endcase
  endfunction

  // --------------------
  // Clock, reset and memory sequencing
  task automatic fill_memories();
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = I_NOP;
      dmem[i] = {16'hd0d0, i[15:0]};
    end
    prog_len = 0;
  endtask

  // One clock, store captured mid-cycle lands on the rising edge
  task automatic step_cycle();
    logic  we;
    word_t addr;
    word_t data;
    we   = dmem_we;
    addr = dmem_waddr;
    data = dmem_wdata;
    @(posedge clk);
    if (we) begin
      dmem[addr[9:2]] = data;
    end
    @(negedge clk);
  endtask

  task automatic start_program();
    @(negedge clk);
    rst_n = 1'b0;
    fill_memories();
  endtask

  task automatic wait_for_ebreak();
    int cycles;
    cycles = 0;
    while (ebreak !== 1'b1 && cycles < PROG_CYCLES) begin
      step_cycle();
      cycles++;
    end
    if (ebreak !== 1'b1) begin
      $display("%s: core did not reach ebreak within %0d cycles", cur_test, PROG_CYCLES);
      note_error();
    end
  endtask

  task automatic run_program();
    repeat (RESET_CYCLES) step_cycle();
    rst_n = 1'b1;
    wait_for_ebreak();
  endtask

  // --------------------
  // Directed tests
  task automatic check_idle_outputs();
    check_word("imem_raddr", 32'd0, imem_raddr);
    check_flag("dmem_ren", 1'b0, dmem_ren);
    check_flag("dmem_we", 1'b0, dmem_we);
    check_flag("ebreak", 1'b0, ebreak);
  endtask

  task automatic check_reset_state();
    open_test("reset");
    start_program();
    halt_program();
    repeat (RESET_CYCLES) begin
      #1;
      check_idle_outputs();
      step_cycle();
    end
    rst_n = 1'b1;
    // First cycle out of reset
    #1;
    check_idle_outputs();
    wait_for_ebreak();
    close_test();
  endtask

  task automatic run_alu_ops();
    word_t      a;
    word_t      b;
    word_t      opnd;
    int         imm12;
    int         shamt;
    logic [2:0] f3;
    open_test("alu");
    a     = $random(seed);
    b     = $random(seed);
    imm12 = $random(seed) & 'hfff;
    shamt = $random(seed) & 'h1f;
    start_program();
    dmem[0] = a;
    dmem[1] = b;
    alu_program(imm12, shamt);
    run_program();
    for (int k = 0; k < 10; k++) begin
      check_word($sformatf("reg op %0d", k), expect_alu(ALU_F3[k], ALU_ALT[k], a, b),
                 dmem[16 + k]);
    end
    for (int k = 0; k < 10; k++) begin
      f3   = ALU_F3[k];
      opnd = (f3 == 3'd1 || f3 == 3'd5) ? word_t'(shamt) : {{20{imm12[11]}}, imm12[11:0]};
      if (k != 1) begin
        check_word($sformatf("imm op %0d", k), expect_alu(f3, ALU_ALT[k], a, opnd),
                   dmem[32 + k]);
      end
    end
    check_word("x0 store", 32'd0, dmem[48]);
    close_test();
  endtask

  task automatic run_branches();
    word_t x;
    word_t y;
    word_t lhs;
    word_t rhs;
    logic  taken;
    open_test("branch");
    // Negative x against positive y splits signed from unsigned order
    x = $random(seed) | 32'h8000_0000;
    y = $random(seed) & 32'h7fff_ffff;
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 2; p++) begin
        if (c < 2) begin
          lhs = x;
          rhs = (p == 0) ? x : y;
        end else begin
          lhs = (p == 0) ? x : y;
          rhs = (p == 0) ? y : x;
        end
        start_program();
        dmem[0] = lhs;
        dmem[1] = rhs;
        branch_program(BR_F3[c]);
        run_program();
        taken = branch_rule(BR_F3[c], lhs, rhs);
        check_word($sformatf("funct3 %0d pair %0d", BR_F3[c], p),
                   taken ? word_t'(MARK_TAKEN) : word_t'(MARK_FALL), dmem[16]);
      end
    end
    close_test();
  endtask

  task automatic run_jumps();
    int lui_imm;
    int auipc_imm;
    open_test("jump");
    lui_imm   = $random(seed) & 'hfffff;
    auipc_imm = $random(seed) & 'hfffff;
    start_program();
    jump_program(lui_imm, auipc_imm);
    run_program();
    // Links are the address after each jump
    check_word("jal link", 32'd8, dmem[16]);
    check_word("jalr link", 32'd28, dmem[17]);
    check_word("skipped paths", 32'd0, dmem[18]);
    check_word("lui", {lui_imm[19:0], 12'h000}, dmem[19]);
    check_word("auipc", 32'd52 + {auipc_imm[19:0], 12'h000}, dmem[20]);
    close_test();
  endtask

  task automatic run_load_store();
    word_t vals [4];
    open_test("load_store");
    start_program();
    for (int i = 0; i < 4; i++) begin
      vals[i]     = $random(seed);
      dmem[8 + i] = vals[i];
    end
    load_store_program();
    run_program();
    check_word("sum 0+1", vals[0] + vals[1], dmem[24]);
    check_word("sum 2+3", vals[2] + vals[3], dmem[25]);
    check_word("total", vals[0] + vals[1] + vals[2] + vals[3], dmem[26]);
    close_test();
  endtask

  task automatic probe_ebreak();
    int    hits;
    word_t exp_addr;
    open_test("ebreak");
    start_program();
    ebreak_program();
    repeat (RESET_CYCLES) step_cycle();
    rst_n = 1'b1;
    hits  = 0;
    // Straight-line code, one word per cycle
    for (int n = 0; n < PROBE_CYCLES; n++) begin
      exp_addr = word_t'(4 * n);
      #1;
      check_word($sformatf("fetch %0d", n), exp_addr, imem_raddr);
      check_flag($sformatf("ebreak at %h", exp_addr), exp_addr == EBREAK_AT, ebreak);
      if (ebreak === 1'b1) begin
        hits++;
      end
      step_cycle();
    end
    check_word("ebreak cycles", 32'd1, word_t'(hits));
    close_test();
  endtask

  // --------------------
  // Test sequence
  initial begin
    rst_n        = 1'b0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    fill_memories();
    check_reset_state();
    run_alu_ops();
    run_branches();
    run_jumps();
    run_load_store();
    probe_ebreak();
    $display("Tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+verif
logic/rv_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_result.sv
logic/rv_core.sv
verif/rv_core_tb.sv
